/* verilog/rvPkg.sv */
package rvPkg;

    localparam int xlen = 32;

    // major opcodes, anything unknown decodes as OpOther
    typedef enum logic [6:0] {
        OpLui    = 7'b0110111,
        OpImm    = 7'b0010011,
        OpReg    = 7'b0110011,
        OpLoad   = 7'b0000011,
        OpStore  = 7'b0100011,
        OpBranch = 7'b1100011,
        OpJal    = 7'b1101111,
        OpOther  = 7'b0000000
    } opcodeT;

    typedef enum logic [2:0] {
        Beq  = 3'b000,
        Bne  = 3'b001,
        Blt  = 3'b100,
        Bge  = 3'b101,
        Bltu = 3'b110,
        Bgeu = 3'b111
    } branchT;

    typedef enum logic [3:0] {
        AluAdd,
        AluSub,
        AluAnd,
        AluOr,
        AluXor,
        AluSlt,
        AluSltu,
        AluPassB
    } aluOpT;

endpackage

/* verilog/branchCompare.sv */
`timescale 1ns/1ps

module branchCompare (
    input  logic                   branch,
    input  rvPkg::branchT          func3,
    input  logic [rvPkg::xlen-1:0] rs1,
    input  logic [rvPkg::xlen-1:0] rs2,
    output logic                   branchN
);

    always_comb begin
        branchN = 1'b0;
        if (branch) begin
            case (func3)
                rvPkg::Beq:  branchN = (rs1 == rs2);
                rvPkg::Bne:  branchN = (rs1 != rs2);
                rvPkg::Blt:  branchN = ($signed(rs1) < $signed(rs2));
                rvPkg::Bge:  branchN = ($signed(rs1) >= $signed(rs2));
                rvPkg::Bltu: branchN = (rs1 < rs2); // raw bit patterns
                rvPkg::Bgeu: branchN = (rs1 >= rs2);
                default:     branchN = 1'b0;
            endcase
        end
    end

endmodule

/* verilog/regFile.sv */
`timescale 1ns/1ps

module regFile (
    input  logic                   clk,
    input  logic                   rstN,
    input  logic [4:0]             rAddr1,
    input  logic [4:0]             rAddr2,
    input  logic [4:0]             wAddr,
    input  logic                   wEn,
    input  logic [rvPkg::xlen-1:0] wData,
    output logic [rvPkg::xlen-1:0] rData1,
    output logic [rvPkg::xlen-1:0] rData2
);

    logic [rvPkg::xlen-1:0] regs [32];

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wEn && wAddr != 5'd0) begin // x0 never written
            regs[wAddr] <= wData;
        end
    end

    assign rData1 = regs[rAddr1];
    assign rData2 = regs[rAddr2];

endmodule

/* verilog/alu.sv */
`timescale 1ns/1ps

module alu (
    input  rvPkg::aluOpT           aluOp,
    input  logic [rvPkg::xlen-1:0] a,
    input  logic [rvPkg::xlen-1:0] b,
    output logic [rvPkg::xlen-1:0] y
);

    always_comb begin
        case (aluOp)
            rvPkg::AluAdd:   y = a + b;
            rvPkg::AluSub:   y = a - b;
            rvPkg::AluAnd:   y = a & b;
            rvPkg::AluOr:    y = a | b;
            rvPkg::AluXor:   y = a ^ b;
            rvPkg::AluSlt: begin
                y = '0;
                y[0] = ($signed(a) < $signed(b));
            end
            rvPkg::AluSltu: begin
                y = '0;
                y[0] = (a < b);
            end
            rvPkg::AluPassB: y = b; // lui
            default:         y = a + b;
        endcase
    end

endmodule

/* verilog/decoder.sv */
`timescale 1ns/1ps

module decoder (
    input  logic [rvPkg::xlen-1:0] instr,
    output rvPkg::opcodeT          opcode,
    output rvPkg::aluOpT           aluOp,
    output rvPkg::branchT          func3,
    output logic [4:0]             rd,
    output logic [4:0]             rs1Idx,
    output logic [4:0]             rs2Idx,
    output logic                   useImm,
    output logic [rvPkg::xlen-1:0] imm
);

    logic [rvPkg::xlen-1:0] immI, immS, immB, immU, immJ;

    assign immI = {{20{instr[31]}}, instr[31:20]};
    assign immS = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign immB = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign immU = {instr[31:12], 12'b0};
    assign immJ = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    assign rd     = instr[11:7];
    assign rs1Idx = instr[19:15];
    assign rs2Idx = instr[24:20];
    assign func3  = rvPkg::branchT'(instr[14:12]);

    always_comb begin
        case (instr[6:0])
            rvPkg::OpLui, rvPkg::OpImm, rvPkg::OpReg, rvPkg::OpLoad,
            rvPkg::OpStore, rvPkg::OpBranch, rvPkg::OpJal:
                opcode = rvPkg::opcodeT'(instr[6:0]);
            default: opcode = rvPkg::OpOther; // runs as a no-op
        endcase
    end

    always_comb begin
        case (instr[14:12])
            3'b010:  aluOp = rvPkg::AluSlt;
            3'b011:  aluOp = rvPkg::AluSltu;
            3'b100:  aluOp = rvPkg::AluXor;
            3'b110:  aluOp = rvPkg::AluOr;
            3'b111:  aluOp = rvPkg::AluAnd;
            3'b000:  aluOp = (opcode == rvPkg::OpReg && instr[30]) ? rvPkg::AluSub : rvPkg::AluAdd;
            default: aluOp = rvPkg::AluAdd;
        endcase
        if (opcode == rvPkg::OpLui) begin
            aluOp = rvPkg::AluPassB;
        end else if (opcode != rvPkg::OpImm && opcode != rvPkg::OpReg) begin
            aluOp = rvPkg::AluAdd; // address add for lw/sw
        end
    end

    always_comb begin
        case (opcode)
            rvPkg::OpLui:    imm = immU;
            rvPkg::OpStore:  imm = immS;
            rvPkg::OpBranch: imm = immB;
            rvPkg::OpJal:    imm = immJ;
            default:         imm = immI;
        endcase
    end

    assign useImm = (opcode == rvPkg::OpImm) || (opcode == rvPkg::OpLoad) ||
                    (opcode == rvPkg::OpStore) || (opcode == rvPkg::OpLui);

endmodule

/* verilog/fetchUnit.sv */
`timescale 1ns/1ps

module fetchUnit #(
    parameter logic [31:0] resetPc   = 32'h0,
    parameter int          addrWidth = 12
) (
    input  logic                   clk,
    input  logic                   rstN,
    input  logic                   redirect,
    input  logic [rvPkg::xlen-1:0] redirectPc,
    input  logic                   instrTake,
    output logic                   instrValid,
    output logic [rvPkg::xlen-1:0] instr,
    output logic [rvPkg::xlen-1:0] instrPc,
    output logic                   fCyc,
    output logic                   fStb,
    output logic                   fWe,
    output logic [addrWidth-1:0]   fAdr,
    output logic [rvPkg::xlen-1:0] fDatW,
    output logic [3:0]             fSel,
    input  logic [rvPkg::xlen-1:0] fDatR,
    input  logic                   fAck
);

    logic [rvPkg::xlen-1:0] fetchPc; // next word to fetch
    logic [rvPkg::xlen-1:0] reqPc;   // word on the bus now
    logic                   stale;
    logic                   accept;

    assign accept = fCyc && fAck && !stale && !redirect;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            fetchPc    <= resetPc;
            reqPc      <= resetPc;
            fCyc       <= 1'b0;
            stale      <= 1'b0;
            instrValid <= 1'b0;
        end else begin
            if (instrTake) begin
                instrValid <= 1'b0;
            end
            if (fCyc && fAck) begin
                fCyc  <= 1'b0;
                stale <= 1'b0;
            end else if (!fCyc && !redirect && (!instrValid || instrTake)) begin
                fCyc  <= 1'b1;
                reqPc <= fetchPc;
            end
            if (accept) begin
                instrValid <= 1'b1;
                fetchPc    <= reqPc + 'd4;
            end
            if (redirect) begin
                fetchPc    <= redirectPc;
                instrValid <= 1'b0;
                if (fCyc && !fAck) begin
                    stale <= 1'b1; // drop this word when ack comes
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            instr   <= fDatR;
            instrPc <= reqPc;
        end
    end

    assign fStb  = fCyc;
    assign fWe   = 1'b0;
    assign fAdr  = reqPc[addrWidth-1:0];
    assign fDatW = '0;
    assign fSel  = 4'hf;

endmodule

/* verilog/loadStoreUnit.sv */
`timescale 1ns/1ps

module loadStoreUnit #(
    parameter int addrWidth = 12
) (
    input  logic                   clk,
    input  logic                   rstN,
    input  logic                   memReq,
    input  logic                   memWrite,
    input  logic [rvPkg::xlen-1:0] memAddr,
    input  logic [rvPkg::xlen-1:0] memWData,
    output logic                   memDone,
    output logic [rvPkg::xlen-1:0] memRData,
    output logic                   lCyc,
    output logic                   lStb,
    output logic                   lWe,
    output logic [addrWidth-1:0]   lAdr,
    output logic [rvPkg::xlen-1:0] lDatW,
    output logic [3:0]             lSel,
    input  logic [rvPkg::xlen-1:0] lDatR,
    input  logic                   lAck
);

    logic start;

    assign start = memReq && !lCyc;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            lCyc    <= 1'b0;
            lWe     <= 1'b0;
            memDone <= 1'b0;
        end else begin
            memDone <= 1'b0;
            if (lCyc && lAck) begin
                lCyc    <= 1'b0;
                memDone <= 1'b1;
            end else if (start) begin
                lCyc <= 1'b1;
                lWe  <= memWrite;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            lAdr  <= memAddr[addrWidth-1:0];
            lDatW <= memWData;
        end
        if (lCyc && lAck) begin
            memRData <= lDatR; // harmless on stores
        end
    end

    assign lStb = lCyc;
    assign lSel = 4'hf; // words only

endmodule

/* verilog/busArbiter.sv */
`timescale 1ns/1ps

module busArbiter #(
    parameter int addrWidth = 12
) (
    input  logic                   clk,
    input  logic                   rstN,
    input  logic                   fCyc,
    input  logic                   fStb,
    input  logic                   fWe,
    input  logic [addrWidth-1:0]   fAdr,
    input  logic [rvPkg::xlen-1:0] fDatW,
    input  logic [3:0]             fSel,
    output logic [rvPkg::xlen-1:0] fDatR,
    output logic                   fAck,
    input  logic                   lCyc,
    input  logic                   lStb,
    input  logic                   lWe,
    input  logic [addrWidth-1:0]   lAdr,
    input  logic [rvPkg::xlen-1:0] lDatW,
    input  logic [3:0]             lSel,
    output logic [rvPkg::xlen-1:0] lDatR,
    output logic                   lAck,
    output logic                   cyc,
    output logic                   stb,
    output logic                   we,
    output logic [addrWidth-1:0]   adr,
    output logic [rvPkg::xlen-1:0] datW,
    output logic [3:0]             sel,
    input  logic [rvPkg::xlen-1:0] datR,
    input  logic                   ack
);

    logic busy;
    logic grantL; // current or last winner
    logic pickL;

    // on a tie the load/store side wins only if fetch won last time
    assign pickL = lCyc && (!fCyc || !grantL);

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            busy   <= 1'b0;
            grantL <= 1'b0;
        end else if (busy) begin
            if (ack) begin
                busy <= 1'b0;
            end
        end else if (fCyc || lCyc) begin
            busy   <= 1'b1;
            grantL <= pickL;
        end
    end

    assign cyc  = busy && (grantL ? lCyc : fCyc);
    assign stb  = busy && (grantL ? lStb : fStb);
    assign we   = grantL ? lWe : fWe;
    assign adr  = grantL ? lAdr : fAdr;
    assign datW = grantL ? lDatW : fDatW;
    assign sel  = grantL ? lSel : fSel;

    assign fAck  = busy && !grantL && ack;
    assign lAck  = busy && grantL && ack;
    assign fDatR = grantL ? '0 : datR;
    assign lDatR = grantL ? datR : '0;

endmodule

/* verilog/coreSequencer.sv */
`timescale 1ns/1ps

module coreSequencer #(
    parameter logic [31:0] resetPc = 32'h0
) (
    input  logic                   clk,
    input  logic                   rstN,
    input  logic                   instrValid,
    input  logic [rvPkg::xlen-1:0] instr,
    input  logic [rvPkg::xlen-1:0] instrPc,
    output logic                   instrTake,
    output logic                   redirect,
    output logic [rvPkg::xlen-1:0] redirectPc,
    output logic [rvPkg::xlen-1:0] execInstr,
    input  rvPkg::opcodeT          opcode,
    input  logic [4:0]             rd,
    input  logic                   useImm,
    input  logic [rvPkg::xlen-1:0] imm,
    input  logic [rvPkg::xlen-1:0] rData2,
    input  logic [rvPkg::xlen-1:0] aluY,
    output logic [rvPkg::xlen-1:0] aluB,
    output logic                   branchEn,
    input  logic                   taken,
    output logic                   memReq,
    output logic                   memWrite,
    output logic [rvPkg::xlen-1:0] memAddr,
    output logic [rvPkg::xlen-1:0] memWData,
    input  logic                   memDone,
    input  logic [rvPkg::xlen-1:0] memRData,
    output logic                   wEn,
    output logic [4:0]             wAddr,
    output logic [rvPkg::xlen-1:0] wData,
    output logic                   halted
);

    typedef enum logic [2:0] {
        SFetch,
        SDecode,
        SExec,
        SMem,
        SWb,
        SHalt
    } stateT;

    stateT                  state;
    logic [rvPkg::xlen-1:0] pc;
    logic [rvPkg::xlen-1:0] result;
    logic                   jump;

    assign jump = (opcode == rvPkg::OpJal) && (imm != '0); // jal 0 halts instead

    assign instrTake  = (state == SFetch) && instrValid;
    assign branchEn   = (state == SExec) && (opcode == rvPkg::OpBranch);
    assign redirect   = (state == SExec) && (jump || (branchEn && taken));
    assign redirectPc = pc + imm;
    assign aluB       = useImm ? imm : rData2;

    assign memReq   = (state == SExec) &&
                      (opcode == rvPkg::OpLoad || opcode == rvPkg::OpStore);
    assign memWrite = (opcode == rvPkg::OpStore);
    assign memAddr  = aluY;
    assign memWData = rData2;

    assign wEn    = (state == SWb);
    assign wAddr  = rd;
    assign wData  = result;
    assign halted = (state == SHalt);

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state     <= SFetch;
            pc        <= resetPc;
            execInstr <= '0;
        end else begin
            case (state)
                SFetch: begin
                    if (instrValid) begin
                        execInstr <= instr;
                        pc        <= instrPc;
                        state     <= SDecode;
                    end
                end
                SDecode: state <= SExec;
                SExec: begin
                    case (opcode)
                        rvPkg::OpLui, rvPkg::OpImm, rvPkg::OpReg: state <= SWb;
                        rvPkg::OpLoad, rvPkg::OpStore:            state <= SMem;
                        rvPkg::OpJal:   state <= jump ? SWb : SHalt;
                        default:        state <= SFetch; // branches and no-ops
                    endcase
                end
                SMem: begin
                    if (memDone) begin
                        state <= memWrite ? SFetch : SWb;
                    end
                end
                SWb:     state <= SFetch;
                default: state <= SHalt;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == SExec) begin
            result <= (opcode == rvPkg::OpJal) ? pc + 'd4 : aluY; // link or alu
        end else if (state == SMem && memDone) begin
            result <= memRData;
        end
    end

endmodule

/* verilog/rvCoreTop.sv */
`timescale 1ns/1ps

module rvCoreTop #(
    parameter logic [31:0] resetPc   = 32'h0,
    parameter int          addrWidth = 12
) (
    input  logic                   clk,
    input  logic                   rstN,
    output logic                   cyc,
    output logic                   stb,
    output logic                   we,
    output logic [addrWidth-1:0]   adr,
    output logic [rvPkg::xlen-1:0] datW,
    output logic [3:0]             sel,
    input  logic [rvPkg::xlen-1:0] datR,
    input  logic                   ack,
    output logic                   halted
);

    // fetch side
    logic                   instrValid, instrTake, redirect;
    logic [rvPkg::xlen-1:0] instr, instrPc, redirectPc;
    logic                   fCyc, fStb, fWe, fAck;
    logic [addrWidth-1:0]   fAdr;
    logic [rvPkg::xlen-1:0] fDatW, fDatR;
    logic [3:0]             fSel;

    // load/store side
    logic                   memReq, memWrite, memDone;
    logic [rvPkg::xlen-1:0] memAddr, memWData, memRData;
    logic                   lCyc, lStb, lWe, lAck;
    logic [addrWidth-1:0]   lAdr;
    logic [rvPkg::xlen-1:0] lDatW, lDatR;
    logic [3:0]             lSel;

    // decode and execute
    logic [rvPkg::xlen-1:0] execInstr, imm, rData1, rData2, aluB, aluY, wData;
    rvPkg::opcodeT          opcode;
    rvPkg::aluOpT           aluOp;
    rvPkg::branchT          func3;
    logic [4:0]             rd, rs1Idx, rs2Idx, wAddr;
    logic                   useImm, wEn, branchEn, taken;

    fetchUnit #(.resetPc(resetPc), .addrWidth(addrWidth)) uFetch (.*);

    loadStoreUnit #(.addrWidth(addrWidth)) uLsu (.*);

    busArbiter #(.addrWidth(addrWidth)) uArb (.*);

    coreSequencer #(.resetPc(resetPc)) uSeq (.*);

    decoder uDec (
        .instr(execInstr),
        .*
    );

    regFile uRegs (
        .clk(clk), .rstN(rstN),
        .rAddr1(rs1Idx), .rAddr2(rs2Idx),
        .wAddr(wAddr), .wEn(wEn), .wData(wData),
        .rData1(rData1), .rData2(rData2)
    );

    alu uAlu (
        .aluOp(aluOp),
        .a(rData1),
        .b(aluB),
        .y(aluY)
    );

    branchCompare uBranch (
        .branch(branchEn),
        .func3(func3),
        .rs1(rData1),
        .rs2(rData2),
        .branchN(taken)
    );

endmodule

/* testbench/rvCoreTb.sv */
`timescale 1ns/1ps

module rvCoreTb;

    localparam int addrWidth   = 12;
    localparam int memWords    = 1 << (addrWidth - 2);
    localparam int dataBase    = 32'h800; // program below, stores above
    localparam int haltTimeout = 60000;
    localparam int refMaxSteps = 20000;

    localparam logic [6:0] opLui    = 7'b0110111;
    localparam logic [6:0] opImm    = 7'b0010011;
    localparam logic [6:0] opReg    = 7'b0110011;
    localparam logic [6:0] opLoad   = 7'b0000011;
    localparam logic [6:0] opStore  = 7'b0100011;
    localparam logic [6:0] opBranch = 7'b1100011;
    localparam logic [6:0] opJal    = 7'b1101111;

    logic                 clk;
    logic                 rstN;
    logic                 cyc, stb, we, ack, halted;
    logic [addrWidth-1:0] adr;
    logic [31:0]          datW, datR;
    logic [3:0]           sel;

    logic [31:0] mem     [memWords];
    logic [31:0] refMem  [memWords];
    logic [31:0] refRegs [32];
    logic [31:0] refPc;
    bit          refHalted;
    logic [31:0] expAddr [$];
    logic [31:0] expData [$];
    logic [31:0] expA, expD;

    integer seed = 32'hacb2_897d;
    int     genPc, genOff;
    int     errCount, storeCount, waitLeft, cycleCount;
    bit     inCycle, haltSeen;

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    rvCoreTop #(.resetPc(32'h0), .addrWidth(addrWidth)) dut_i (
        .clk(clk), .rstN(rstN),
        .cyc(cyc), .stb(stb), .we(we), .adr(adr),
        .datW(datW), .sel(sel), .datR(datR), .ack(ack),
        .halted(halted)
    );

    function automatic logic [31:0] rType(input logic [6:0] f7, input logic [2:0] f3,
                                          input logic [4:0] rd, input logic [4:0] rs1,
                                          input logic [4:0] rs2);
        return {f7, rs2, rs1, f3, rd, opReg};
    endfunction

    function automatic logic [31:0] iType(input logic [6:0] op, input logic [2:0] f3,
                                          input logic [4:0] rd, input logic [4:0] rs1,
                                          input logic [11:0] imm);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] sType(input logic [4:0] rs1, input logic [4:0] rs2,
                                          input logic [11:0] imm);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], opStore};
    endfunction

    function automatic logic [31:0] bType(input logic [2:0] f3, input logic [4:0] rs1,
                                          input logic [4:0] rs2, input logic [12:0] imm);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], opBranch};
    endfunction

    function automatic logic [31:0] uType(input logic [4:0] rd, input logic [19:0] imm);
        return {imm, rd, opLui};
    endfunction

    function automatic logic [31:0] jType(input logic [4:0] rd, input logic [20:0] imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, opJal};
    endfunction

    task automatic writeInstr(input logic [31:0] w);
        mem[genPc >> 2] = w;
        genPc += 4;
    endtask

    // sw rs, genOff(x31)
    task automatic emitStore(input logic [4:0] rs);
        writeInstr(sType(5'd31, rs, genOff[11:0]));
        genOff = (genOff + 4) % 2048;
    endtask

    task automatic loadConst(input logic [4:0] rd, input logic [31:0] v);
        logic [31:0] upper;
        upper = (v + 32'h800) >> 12; // addi sign-extends the low part
        writeInstr(uType(rd, upper[19:0]));
        writeInstr(iType(opImm, 3'b000, rd, rd, v[11:0]));
    endtask

    task automatic randomAluBlock(input int count);
        int          kind;
        logic [4:0]  rd, rs1, rs2;
        logic [31:0] r;
        for (int i = 0; i < count; i++) begin
            kind = $unsigned($random(seed)) % 13;
            rd   = 1 + $unsigned($random(seed)) % 30; // x31 stays the base
            rs1  = $unsigned($random(seed)) % 32;
            rs2  = $unsigned($random(seed)) % 32;
            r    = $random(seed);
            case (kind)
                0:  writeInstr(iType(opImm, 3'b000, rd, rs1, r[11:0]));
                1:  writeInstr(iType(opImm, 3'b010, rd, rs1, r[11:0]));
                2:  writeInstr(iType(opImm, 3'b100, rd, rs1, r[11:0]));
                3:  writeInstr(iType(opImm, 3'b110, rd, rs1, r[11:0]));
                4:  writeInstr(iType(opImm, 3'b111, rd, rs1, r[11:0]));
                5:  writeInstr(rType(7'h00, 3'b000, rd, rs1, rs2));
                6:  writeInstr(rType(7'h20, 3'b000, rd, rs1, rs2));
                7:  writeInstr(rType(7'h00, 3'b010, rd, rs1, rs2));
                8:  writeInstr(rType(7'h00, 3'b011, rd, rs1, rs2));
                9:  writeInstr(rType(7'h00, 3'b100, rd, rs1, rs2));
                10: writeInstr(rType(7'h00, 3'b110, rd, rs1, rs2));
                11: writeInstr(rType(7'h00, 3'b111, rd, rs1, rs2));
                default: writeInstr(uType(rd, r[19:0]));
            endcase
        end
        for (int i = 0; i < 32; i++) begin
            emitStore(5'(i));
        end
    endtask

    task automatic branchCases();
        logic [2:0]  codes [6];
        logic [31:0] a, b;
        int          caseNum;
        codes   = '{3'b000, 3'b001, 3'b100, 3'b101, 3'b110, 3'b111};
        caseNum = 1;
        for (int t = 0; t < 6; t++) begin
            for (int p = 0; p < 6; p++) begin
                a = $random(seed);
                b = $random(seed);
                case (p)
                    1: b = a;
                    2: begin
                        a = 32'h8000_0000;
                        b = 32'h7fff_ffff;
                    end
                    3: begin
                        a = 32'h7fff_ffff;
                        b = 32'h8000_0000;
                    end
                    4: begin
                        a = 32'h0;
                        b = 32'hffff_ffff;
                    end
                    5: begin
                        a = 32'hffff_ffff;
                        b = 32'h0;
                    end
                    default: ;
                endcase
                loadConst(5'd5, a);
                loadConst(5'd6, b);
                writeInstr(iType(opImm, 3'b000, 5'd7, 5'd0, caseNum[11:0]));
                writeInstr(bType(codes[t], 5'd5, 5'd6, 13'd8)); // taken skips the marker
                emitStore(5'd7);
                caseNum++;
            end
        end
    endtask

    task automatic memoryCases();
        int off;
        off = genOff;
        loadConst(5'd5, $random(seed));
        emitStore(5'd5);
        writeInstr(iType(opLoad, 3'b010, 5'd8, 5'd31, off[11:0]));
        emitStore(5'd8);
        writeInstr(iType(opLoad, 3'b010, 5'd0, 5'd31, off[11:0])); // load into x0
        emitStore(5'd0);
        writeInstr(iType(opImm, 3'b000, 5'd0, 5'd5, 12'h123));
        emitStore(5'd0);
        writeInstr(iType(opLoad, 3'b010, 5'd9, 5'd31, 12'h7f0)); // untouched word
        emitStore(5'd9);
    endtask

    task automatic jumpCases();
        int loopPc;
        writeInstr(jType(5'd9, 21'd8));
        writeInstr(iType(opImm, 3'b000, 5'd9, 5'd0, 12'd1)); // jumped over
        emitStore(5'd9);
        writeInstr(iType(opImm, 3'b000, 5'd10, 5'd0, 12'd5));
        loopPc = genPc;
        emitStore(5'd10);
        writeInstr(iType(opImm, 3'b000, 5'd10, 5'd10, 12'hfff));
        writeInstr(bType(3'b000, 5'd10, 5'd0, 13'd8));
        writeInstr(jType(5'd0, 21'(loopPc - genPc)));
    endtask

    task automatic buildProgram();
        for (int i = 0; i < memWords; i++) begin
            mem[i] = 32'h1357_2468 + i * 32'h9e37_79b9;
        end
        genPc  = 0;
        genOff = 0;
        writeInstr(iType(opImm, 3'b000, 5'd31, 5'd0, 12'h7ff));
        writeInstr(iType(opImm, 3'b000, 5'd31, 5'd31, 12'h001)); // x31 = 0x800
        randomAluBlock(24);
        randomAluBlock(24);
        branchCases();
        memoryCases();
        jumpCases();
        writeInstr(jType(5'd0, 21'd0)); // jump to itself
        if (genPc > dataBase) begin
            $display("generated program runs into the data area at %h", genPc);
            errCount++;
        end
    endtask

    function automatic logic [31:0] aluResult(input logic [2:0] f3, input bit isSub,
                                              input logic [31:0] a, input logic [31:0] b);
        case (f3)
            3'b000:  return isSub ? a - b : a + b;
            3'b010:  return {31'b0, $signed(a) < $signed(b)};
            3'b011:  return {31'b0, a < b};
            3'b100:  return a ^ b;
            3'b110:  return a | b;
            3'b111:  return a & b;
            default: return 32'h0;
        endcase
    endfunction

    function automatic bit branchTaken(input logic [2:0] f3, input logic [31:0] a,
                                       input logic [31:0] b);
        case (f3)
            3'b000:  return a == b;
            3'b001:  return a != b;
            3'b100:  return $signed(a) < $signed(b);
            3'b101:  return $signed(a) >= $signed(b);
            3'b110:  return a < b;
            3'b111:  return a >= b;
            default: return 1'b0;
        endcase
    endfunction

    function automatic void setShadowReg(input logic [4:0] rd, input logic [31:0] v);
        if (rd != 5'd0) begin
            refRegs[rd] = v;
        end
    endfunction

    // one instruction on the shadow state, returns 1 with the store it made
    function automatic bit refStep(output logic [31:0] stAddr, output logic [31:0] stData);
        logic [31:0] w, a, b, immI, immS, immB, immJ, addr, nextPc;
        logic [4:0]  rd;
        logic [2:0]  f3;
        bit          isStore;
        w       = refMem[refPc[addrWidth-1:2]];
        rd      = w[11:7];
        f3      = w[14:12];
        a       = refRegs[w[19:15]];
        b       = refRegs[w[24:20]];
        immI    = {{20{w[31]}}, w[31:20]};
        immS    = {{20{w[31]}}, w[31:25], w[11:7]};
        immB    = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
        immJ    = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
        nextPc  = refPc + 32'd4;
        isStore = 1'b0;
        stAddr  = '0;
        stData  = '0;
        case (w[6:0])
            opLui:  setShadowReg(rd, {w[31:12], 12'b0});
            opImm:  setShadowReg(rd, aluResult(f3, 1'b0, a, immI));
            opReg:  setShadowReg(rd, aluResult(f3, w[30], a, b));
            opLoad: begin
                addr = a + immI;
                setShadowReg(rd, refMem[addr[addrWidth-1:2]]);
            end
            opStore: begin
                addr    = a + immS;
                refMem[addr[addrWidth-1:2]] = b;
                stAddr  = addr[addrWidth-1:0];
                stData  = b;
                isStore = 1'b1;
            end
            opBranch: begin
                if (branchTaken(f3, a, b)) begin
                    nextPc = refPc + immB;
                end
            end
            opJal: begin
                if (immJ == 32'h0) begin
                    refHalted = 1'b1;
                end else begin
                    setShadowReg(rd, refPc + 32'd4);
                    nextPc = refPc + immJ;
                end
            end
            default: ; // no-op
        endcase
        if (!refHalted) begin
            refPc = nextPc;
        end
        return isStore;
    endfunction

    task automatic runReference();
        logic [31:0] sa, sd;
        int          steps;
        for (int i = 0; i < memWords; i++) begin
            refMem[i] = mem[i];
        end
        for (int i = 0; i < 32; i++) begin
            refRegs[i] = 32'h0;
        end
        refPc     = 32'h0;
        refHalted = 1'b0;
        steps     = 0;
        while (!refHalted && steps < refMaxSteps) begin
            if (refStep(sa, sd)) begin
                expAddr.push_back(sa);
                expData.push_back(sd);
            end
            steps++;
        end
        if (!refHalted) begin
            $display("reference model did not reach the halt jump");
            errCount++;
        end
    endtask

    // memory slave, 0 to 3 wait states, ack held one cycle
    always @(posedge clk) begin
        #1;
        if (ack) begin
            ack = 1'b0;
        end else if (cyc && stb) begin
            if (!inCycle) begin
                inCycle  = 1'b1;
                waitLeft = $unsigned($random(seed)) % 4;
            end
            if (waitLeft == 0) begin
                ack     = 1'b1;
                inCycle = 1'b0;
                if (we) begin
                    mem[adr[addrWidth-1:2]] = datW;
                end else begin
                    datR = mem[adr[addrWidth-1:2]];
                end
            end else begin
                waitLeft--;
            end
        end
    end

    // store comparator
    always @(negedge clk) begin
        if (cyc && stb && we && ack) begin
            if (haltSeen) begin
                $display("bus write to %h after halted rose", adr);
                errCount++;
            end else if (expAddr.size() == 0) begin
                $display("bus write to %h with no store left in the reference stream", adr);
                errCount++;
            end else begin
                expA = expAddr.pop_front();
                expD = expData.pop_front();
                if (adr !== expA[addrWidth-1:0]) begin
                    $display("Fail adr: expected %h, got %h", expA[addrWidth-1:0], adr);
                    errCount++;
                end
                if (datW !== expD) begin
                    $display("Fail datW: expected %h, got %h", expD, datW);
                    errCount++;
                end
                if (sel !== 4'hf) begin
                    $display("Fail sel: expected %h, got %h", 4'hf, sel);
                    errCount++;
                end
                storeCount++;
            end
        end
        if (halted) begin
            haltSeen = 1'b1;
        end
    end

    initial begin
        rstN       = 1'b0;
        ack        = 1'b0;
        datR       = '0;
        errCount   = 0;
        storeCount = 0;
        waitLeft   = 0;
        inCycle    = 1'b0;
        haltSeen   = 1'b0;
        buildProgram();
        runReference();
        repeat (8) @(posedge clk);
        if (cyc !== 1'b0 || stb !== 1'b0 || halted !== 1'b0) begin
            $display("bus or halted not idle during reset");
            errCount++;
        end
        #1;
        rstN = 1'b1;
        cycleCount = 0;
        while (halted !== 1'b1 && cycleCount < haltTimeout) begin
            @(negedge clk);
            cycleCount++;
        end
        if (halted !== 1'b1) begin
            $display("timeout: halted did not rise within %0d cycles", haltTimeout);
            errCount++;
        end else begin
            repeat (20) @(negedge clk); // window for stray writes after halt
            if (expAddr.size() != 0) begin
                $display("%0d expected stores never appeared on the bus", expAddr.size());
                errCount++;
            end
        end
        $display("stores checked %0d, errors %0d", storeCount, errCount);
        if (errCount == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

/* project.f */
verilog/rvPkg.sv
verilog/branchCompare.sv
verilog/regFile.sv
verilog/alu.sv
verilog/decoder.sv
verilog/fetchUnit.sv
verilog/loadStoreUnit.sv
verilog/busArbiter.sv
verilog/coreSequencer.sv
verilog/rvCoreTop.sv
testbench/rvCoreTb.sv
